//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module led_bank_tb -f sim.f -o led_bank_sim

out=$(./obj_dir/led_bank_sim)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
   exit 0
fi
exit 1

//--- sim.f
src/ledbank_pkg.sv
src/apb_pkg.sv
src/apb_inst_port.sv
src/inst_fifo.sv
src/led_bank.sv
src/led_bank_top.sv
sim/clock_gen.sv
sim/led_bank_properties.sv
sim/led_bank_tb.sv

//--- sim/clock_gen.sv
module clock_gen (
   output logic clock,
   output logic reset
);

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;   // period 20
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clock);
      reset <= 1'b0;
   end

endmodule

//--- sim/led_bank_properties.sv
module led_bank_properties (
   input  logic               clock,
   input  logic               reset,
   input  apb_pkg::apb_req_t  apb_req,
   input  apb_pkg::apb_rsp_t  apb_rsp,
   input  logic [7:0]         leds
);

   logic access;
   logic inst_write;
   logic status_done;

   assign access      = apb_req.psel & apb_req.penable;
   assign inst_write  = access & apb_req.pwrite & (apb_req.paddr == apb_pkg::INST_ADDR);
   assign status_done = access & ~apb_req.pwrite & apb_rsp.pready &
                        (apb_req.paddr == apb_pkg::STATUS_ADDR);

   slverr_in_access: assert property (@(posedge clock) disable iff (reset)
      apb_rsp.pslverr |-> (access && apb_rsp.pready))
      else $error("pslverr raised outside a completing access");

   ready_low_on_write: assert property (@(posedge clock) disable iff (reset)
      !apb_rsp.pready |-> inst_write)
      else $error("pready held low outside an instruction write");

   // error state reported on the bus means dark leds
   error_leds_dark: assert property (@(posedge clock) disable iff (reset)
      (status_done && apb_rsp.prdata[9:8] == ledbank_pkg::ERROR_ST)
         |-> (apb_rsp.prdata[7:0] == 8'h00 && leds == 8'h00))
      else $error("leds not zero while status reports the error state");

endmodule

bind led_bank_top led_bank_properties led_bank_properties_inst (
   .clock   (clock),
   .reset   (reset),
   .apb_req (apb_req),
   .apb_rsp (apb_rsp),
   .leds    (leds)
);

//--- sim/led_bank_tb.sv
module led_bank_tb;

   localparam int DRIVE_DLY = 2;
   localparam int TIMEOUT   = 40;

   logic                  clock;
   logic                  reset;
   apb_pkg::apb_req_t     apb_req;
   apb_pkg::apb_rsp_t     apb_rsp;
   logic [7:0]            leds;
   ledbank_pkg::status_t  model;   // expected bank state
   logic [31:0]           rng_state = 32'd32;
   logic                  timed_out = 1'b0;
   int                    timeouts  = 0;
   int                    errors    = 0;
   int                    checks    = 0;
   int                    check_seq = 0;
   int                    check_ack = 0;
   logic [31:0]           check_got;
   logic [31:0]           check_exp;
   string                 check_what;

   clock_gen clock_gen_inst (.clock(clock), .reset(reset));

   led_bank_top led_bank_top_inst (
      .clock   (clock),
      .reset   (reset),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .leds    (leds)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic ledbank_pkg::status_t ref_apply(input ledbank_pkg::status_t cur,
                                                      input logic [11:0] word);
      ledbank_pkg::status_t nxt;
      logic [3:0]           op;
      nxt = cur;
      op  = word[11:8];
      if (cur.state != ledbank_pkg::ERROR_ST) begin   // error swallows everything
         if (op == 4'd1) begin
            nxt.leds = word[7:0];
         end else if (op >= 4'd2 && op <= 4'd9) begin
            nxt.leds[3'(op - 4'd2)] = word[0];
         end else if (op != 4'd0) begin
            nxt.state = ledbank_pkg::ERROR_ST;
            nxt.leds  = 8'h00;
         end
      end
      return nxt;
   endfunction

   task automatic note_timeout(input string what);
      $display("timeout while %s", what);
      timed_out = 1'b1;
      timeouts++;
   endtask

   // one compare per sequence step
   always @(negedge clock) begin
      if (check_ack != check_seq) begin
         checks++;
         assert (check_got == check_exp) else begin
            $display("mismatch at %0t: %s got %0h expected %0h",
                     $time, check_what, check_got, check_exp);
            errors++;
         end
         check_ack = check_seq;
      end
   end

   task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
      int tries;
      tries = 0;
      if (timed_out) return;
      check_got  = got;
      check_exp  = exp;
      check_what = what;
      check_seq++;
      while (check_ack != check_seq) begin
         @(posedge clock);
         #DRIVE_DLY;
         tries++;
         if (tries == TIMEOUT) begin
            note_timeout("waiting for the compare process");
            break;
         end
      end
   endtask

   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err, output int waits);
      int tries;
      tries = 0;
      waits = 0;
      rdata = '0;
      err   = 1'b0;
      if (timed_out) return;
      apb_req.psel    = 1'b1;   // setup phase
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clock);
      #DRIVE_DLY;
      apb_req.penable = 1'b1;
      while (1) begin
         @(negedge clock);
         if (apb_rsp.pready) break;
         waits++;
         tries++;
         if (tries == TIMEOUT) begin
            note_timeout("an APB access never completed");
            break;
         end
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clock);
      #DRIVE_DLY;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic send_inst(input logic [11:0] word, output logic err, output int waits);
      logic [31:0] unused_rdata;
      apb_access(1'b1, apb_pkg::INST_ADDR, {20'd0, word}, unused_rdata, err, waits);
      model = ref_apply(model, word);
   endtask

   task automatic drain_and_check();
      logic [31:0] rdata;
      logic        err;
      int          waits;
      int          tries;
      tries = 0;
      rdata = '0;
      err   = 1'b0;
      while (!timed_out) begin
         apb_access(1'b0, apb_pkg::STATUS_ADDR, 32'd0, rdata, err, waits);
         if (rdata[18:16] == 3'd0) break;
         tries++;
         if (tries == TIMEOUT) note_timeout("the instruction queue never drained");
      end
      expect_value(32'(leds), 32'(model.leds), "leds port");
      expect_value(32'(rdata[7:0]), 32'(model.leds), "status leds");
      expect_value(32'(rdata[9:8]), 32'(model.state), "status state");
      expect_value(32'(err), 32'd0, "pslverr on status read");
   endtask

   task automatic report_test(input int num, input string name, input int start_errors,
                              input string note);
      $display("test %0d %s finished, %0d errors%s", num, name, errors - start_errors, note);
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] rdata;
      logic [11:0] word;
      logic [3:0]  op;
      logic        err;
      logic        any_err;
      int          waits;
      int          total_waits;
      int          start;
      int          tries;
      apb_req = '0;
      tries   = 0;
      while (reset !== 1'b0) begin
         @(negedge clock);
         tries++;
         if (tries == TIMEOUT) begin
            note_timeout("reset was never released");
            break;
         end
      end
      @(posedge clock);
      #DRIVE_DLY;
      model.leds  = 8'h00;
      model.state = ledbank_pkg::READY_ST;

      start = errors;
      repeat (6) begin
         r    = next_rand();
         word = {4'd1, r[23:16]};
         send_inst(word, err, waits);
         expect_value(32'(err), 32'd0, "pslverr on LDI write");
         drain_and_check();
      end
      report_test(1, "ldi immediates", start, "");

      start = errors;
      r = next_rand();
      send_inst({4'd1, r[15:8]}, err, waits);
      drain_and_check();
      repeat (12) begin
         r    = next_rand();
         word = {4'd2 + {1'b0, r[18:16]}, 7'd0, r[24]};
         send_inst(word, err, waits);
         expect_value(32'(err), 32'd0, "pslverr on LDn write");
         drain_and_check();
         send_inst({4'd0, r[7:0]}, err, waits);   // NOP keeps the pattern
         drain_and_check();
      end
      report_test(2, "single led loads", start, "");

      start       = errors;
      total_waits = 0;
      any_err     = 1'b0;
      repeat (ledbank_pkg::FIFO_DEPTH + 4) begin
         r    = next_rand();
         op   = r[27:24] % 4'd10;
         word = {op, r[7:0]};
         send_inst(word, err, waits);
         total_waits += waits;
         any_err     |= err;
      end
      expect_value(32'(any_err), 32'd0, "pslverr during burst");
      drain_and_check();
      report_test(3, "write burst", start, $sformatf(", %0d wait cycles", total_waits));

      start = errors;
      apb_access(1'b0, apb_pkg::STATUS_ADDR, 32'd0, rdata, err, waits);
      expect_value(32'(rdata[9:8]), 32'(ledbank_pkg::READY_ST), "idle status state");
      expect_value(32'(rdata[18:16]), 32'd0, "idle status level");
      apb_access(1'b1, apb_pkg::STATUS_ADDR, {20'd0, 4'd1, ~model.leds}, rdata, err,
                 waits);   // an LDI that would flip every led if queued
      expect_value(32'(err), 32'd1, "pslverr on status write");
      apb_access(1'b0, 8'h08, 32'd0, rdata, err, waits);
      expect_value(32'(err), 32'd1, "pslverr on unmapped read");
      apb_access(1'b0, apb_pkg::INST_ADDR, 32'd0, rdata, err, waits);
      expect_value(rdata, 32'd0, "instruction register read data");
      expect_value(32'(err), 32'd0, "pslverr on instruction read");
      expect_value(32'(leds), 32'(model.leds), "leds after bad accesses");
      report_test(4, "status and bus errors", start, "");

      start = errors;
      r     = next_rand();
      op    = 4'd10 + (r[27:24] % 4'd6);
      send_inst({op, r[7:0]}, err, waits);
      drain_and_check();
      r = next_rand();
      send_inst({4'd1, r[23:16] | 8'h01}, err, waits);   // ignored in the error state
      drain_and_check();
      report_test(5, "illegal opcode", start, "");

      $display("tests 5, checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- src/apb_inst_port.sv
module apb_inst_port (
   input  logic                              clock,
   input  logic                              reset,
   input  apb_pkg::apb_req_t                 apb_req,
   output apb_pkg::apb_rsp_t                 apb_rsp,
   input  logic                              full,
   input  logic [ledbank_pkg::LEVEL_W-1:0]   level,
   input  ledbank_pkg::status_t              status,
   output logic                              push,
   output ledbank_pkg::inst_t                push_inst
);

   logic        setup;
   logic        access;
   logic        inst_wr;
   logic        inst_rd;
   logic        stat_rd;
   logic        bad_acc;
   logic        stat_sel_q;   // setup phase addressed the status register
   logic [31:0] rdata_d;
   logic [31:0] rdata_q;

   assign setup  = apb_req.psel & ~apb_req.penable;
   assign access = apb_req.psel & apb_req.penable;

   assign inst_wr = access & apb_req.pwrite & (apb_req.paddr == apb_pkg::INST_ADDR);
   assign inst_rd = access & ~apb_req.pwrite & (apb_req.paddr == apb_pkg::INST_ADDR);
   assign stat_rd = access & ~apb_req.pwrite & (apb_req.paddr == apb_pkg::STATUS_ADDR);
   assign bad_acc = access & ~(inst_wr | inst_rd | stat_rd);

   // back-pressure only while the queue is full
   assign push      = inst_wr & ~full;
   assign push_inst = apb_req.pwdata[11:0];

   always_comb begin
      rdata_d = '0;
      rdata_d[apb_pkg::STAT_LEDS_LSB +: 8]                   = status.leds;
      rdata_d[apb_pkg::STAT_STATE_LSB +: 2]                  = status.state;
      rdata_d[apb_pkg::STAT_LEVEL_LSB +: ledbank_pkg::LEVEL_W] = level;
   end

   // snapshot taken on the edge that opens the access phase
   always_ff @(posedge clock) begin
      if (setup) begin
         rdata_q <= rdata_d;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         stat_sel_q <= 1'b0;
      end else if (setup) begin
         stat_sel_q <= ~apb_req.pwrite & (apb_req.paddr == apb_pkg::STATUS_ADDR);
      end
   end

   always_comb begin
      apb_rsp.pready  = ~(inst_wr & full);
      apb_rsp.pslverr = bad_acc;
      apb_rsp.prdata  = (stat_rd & stat_sel_q) ? rdata_q : '0;   // inst reads give zero
   end

endmodule

//--- src/apb_pkg.sv
package apb_pkg;

   localparam logic [7:0] INST_ADDR   = 8'h00;   // write only, reads as zero
   localparam logic [7:0] STATUS_ADDR = 8'h04;   // read only

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic        pready;
      logic        pslverr;
      logic [31:0] prdata;
   } apb_rsp_t;

   // status word layout
   localparam int STAT_LEDS_LSB  = 0;
   localparam int STAT_STATE_LSB = 8;
   localparam int STAT_LEVEL_LSB = 16;

endpackage

//--- src/inst_fifo.sv
module inst_fifo (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             push,
   input  ledbank_pkg::inst_t               push_inst,
   input  logic                             pop,
   output logic                             valid,
   output ledbank_pkg::inst_t               head_inst,
   output logic                             full,
   output logic [ledbank_pkg::LEVEL_W-1:0]  level
);

   localparam int PTR_W = $clog2(ledbank_pkg::FIFO_DEPTH);

   ledbank_pkg::inst_t               mem [ledbank_pkg::FIFO_DEPTH];
   logic [PTR_W-1:0]                 wr_ptr;
   logic [PTR_W-1:0]                 rd_ptr;
   logic [ledbank_pkg::LEVEL_W-1:0]  count;

   always_ff @(posedge clock) begin
      if (push) begin
         mem[wr_ptr] <= push_inst;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(ledbank_pkg::FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(ledbank_pkg::FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   assign valid     = (count != '0);
   assign full      = (count == ledbank_pkg::LEVEL_W'(ledbank_pkg::FIFO_DEPTH));
   assign level     = count;
   assign head_inst = mem[rd_ptr];

endmodule

//--- src/led_bank.sv
module led_bank (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  valid,
   input  ledbank_pkg::inst_t    head_inst,
   output logic                  pop,
   output logic [7:0]            leds,
   output ledbank_pkg::status_t  status
);

   ledbank_pkg::bank_state_t state_q;
   logic [7:0]               leds_q;
   ledbank_pkg::opcode_t     op;
   logic [2:0]               bit_idx;

   assign op      = head_inst.imm.opcode;
   assign bit_idx = 3'(op - ledbank_pkg::LD0);   // LDn selects led n

   // error state drains the queue without acting on it
   assign pop = valid & ((state_q == ledbank_pkg::READY_ST) |
                         (state_q == ledbank_pkg::ERROR_ST));

   always_ff @(posedge clock) begin
      if (reset) begin
         state_q <= ledbank_pkg::RESET_ST;
         leds_q  <= '0;
      end else begin
         case (state_q)
            ledbank_pkg::RESET_ST: begin
               state_q <= ledbank_pkg::READY_ST;
               leds_q  <= '0;
            end
            ledbank_pkg::READY_ST: begin
               if (pop) begin
                  case (op)
                     ledbank_pkg::NOP: ;
                     ledbank_pkg::LDI: leds_q <= head_inst.imm.imm;
                     ledbank_pkg::LD0, ledbank_pkg::LD1, ledbank_pkg::LD2,
                     ledbank_pkg::LD3, ledbank_pkg::LD4, ledbank_pkg::LD5,
                     ledbank_pkg::LD6, ledbank_pkg::LD7: begin
                        leds_q[bit_idx] <= head_inst.bits.value;
                     end
                     default: begin   // illegal opcode, sticky
                        state_q <= ledbank_pkg::ERROR_ST;
                        leds_q  <= '0;
                     end
                  endcase
               end
            end
            default: begin
               state_q <= ledbank_pkg::ERROR_ST;
               leds_q  <= '0;
            end
         endcase
      end
   end

   assign leds         = leds_q;
   assign status.leds  = leds_q;
   assign status.state = state_q;

endmodule

//--- src/led_bank_top.sv
module led_bank_top (
   input  logic               clock,
   input  logic               reset,
   input  apb_pkg::apb_req_t  apb_req,
   output apb_pkg::apb_rsp_t  apb_rsp,
   output logic [7:0]         leds
);

   logic                             push;
   ledbank_pkg::inst_t               push_inst;
   logic                             full;
   logic [ledbank_pkg::LEVEL_W-1:0]  level;
   logic                             valid;
   ledbank_pkg::inst_t               head_inst;
   logic                             pop;
   ledbank_pkg::status_t             status;

   apb_inst_port apb_inst_port_inst (
      .clock     (clock),
      .reset     (reset),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .full      (full),
      .level     (level),
      .status    (status),
      .push      (push),
      .push_inst (push_inst)
   );

   inst_fifo inst_fifo_inst (
      .clock     (clock),
      .reset     (reset),
      .push      (push),
      .push_inst (push_inst),
      .pop       (pop),
      .valid     (valid),
      .head_inst (head_inst),
      .full      (full),
      .level     (level)
   );

   led_bank led_bank_inst (
      .clock     (clock),
      .reset     (reset),
      .valid     (valid),
      .head_inst (head_inst),
      .pop       (pop),
      .leds      (leds),
      .status    (status)
   );

endmodule

//--- src/ledbank_pkg.sv
package ledbank_pkg;

   localparam int FIFO_DEPTH = 4;
   localparam int LEVEL_W    = 3;   // holds 0..FIFO_DEPTH

   typedef enum logic [3:0] {
      NOP = 4'd0,
      LDI = 4'd1,
      LD0 = 4'd2,
      LD1 = 4'd3,
      LD2 = 4'd4,
      LD3 = 4'd5,
      LD4 = 4'd6,
      LD5 = 4'd7,
      LD6 = 4'd8,
      LD7 = 4'd9
   } opcode_t;   // 10..15 are illegal

   typedef struct packed {
      opcode_t    opcode;
      logic [7:0] imm;
   } imm_form_t;   // LDI

   typedef struct packed {
      opcode_t    opcode;
      logic [6:0] pad;
      logic       value;
   } bit_form_t;   // LD0..LD7

   typedef union packed {
      imm_form_t imm;
      bit_form_t bits;
   } inst_t;

   typedef enum logic [1:0] {
      RESET_ST = 2'd0,
      READY_ST = 2'd1,
      ERROR_ST = 2'd2
   } bank_state_t;

   typedef struct packed {
      logic [7:0]  leds;
      bank_state_t state;
   } status_t;

endpackage
